// File: src/rvPkg.sv
package rvPkg;

    localparam int xLen = 64;

    // major opcodes used by the core
    typedef enum logic [6:0] {
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opBranch = 7'b1100011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opImm    = 7'b0010011,
        opImmW   = 7'b0011011,
        opReg    = 7'b0110011,
        opRegW   = 7'b0111011,
        opSystem = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluCopyB
    } aluOpE;

    typedef enum logic [2:0] {
        immI, immS, immB, immU, immJ
    } immKindE;

    // nine next-PC rules, so four bits
    typedef enum logic [3:0] {
        brNone, brJal, brJalr, brEq, brNe, brLt, brGe, brLtu, brGeu
    } branchKindE;

    // same coding as funct3 of loads and stores
    typedef enum logic [2:0] {
        memByte   = 3'b000,
        memHalf   = 3'b001,
        memWord   = 3'b010,
        memDouble = 3'b011,
        memByteU  = 3'b100,
        memHalfU  = 3'b101,
        memWordU  = 3'b110
    } memOpE;

    typedef struct packed {
        aluOpE      aluOp;
        logic       aSelPc;
        logic       bSelImm;
        logic       isWord;
        logic       regWr;
        logic       memRd;
        logic       memWr;
        memOpE      memOp;
        branchKindE branch;
        immKindE    immKind;
        logic       isEbreak;
    } ctrlT;

    typedef struct packed {
        logic            valid;
        logic            write;
        logic [xLen-1:0] addr;
        logic [xLen-1:0] wdata;
        logic [7:0]      wmask;
    } memReqT;

    typedef struct packed {
        logic            valid;
        logic [xLen-1:0] pc;
        logic [31:0]     inst;
        logic [4:0]      rdAddr;
        logic            rdWr;
        logic [xLen-1:0] rdData;
    } retireT;

endpackage

// File: src/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit #(
    parameter logic [rvPkg::xLen-1:0] resetPc = '0
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   run,
    input  logic                   fetchGnt,
    input  logic [rvPkg::xLen-1:0] memRdata,
    input  rvPkg::ctrlT            ctrl,
    input  logic [rvPkg::xLen-1:0] imm,
    input  logic [rvPkg::xLen-1:0] rs1Data,
    input  logic                   aluLess,
    input  logic                   aluZero,
    input  logic                   execDone,
    output rvPkg::memReqT          fetchReq,
    output logic [rvPkg::xLen-1:0] pc,
    output logic [31:0]            inst,
    output logic                   execPhase,
    output logic                   retireValid,
    output logic                   halted
);
    import rvPkg::*;

    logic            taken;
    logic [xLen-1:0] nextPc;

    // read the instruction word only in the fetch phase
    always_comb begin
        fetchReq       = '0;
        fetchReq.valid = run && !execPhase && !halted;
        fetchReq.addr  = pc;
    end

    always_comb begin
        case (ctrl.branch)
            brJal, brJalr: taken = 1'b1;
            brEq:          taken = aluZero;
            brNe:          taken = !aluZero;
            brLt, brLtu:   taken = aluLess;
            brGe, brGeu:   taken = !aluLess;
            default:       taken = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    assign nextPc = (ctrl.branch == brJalr) ? ((rs1Data + imm) & ~xLen'(1)) :
                    taken                   ? (pc + imm) :
                                              (pc + xLen'(4));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc          <= resetPc;
            execPhase   <= 1'b0;
            retireValid <= 1'b0;
            halted      <= 1'b0;
        end else begin
            retireValid <= 1'b0;
            if (!execPhase) begin
                if (fetchReq.valid && fetchGnt) begin
                    execPhase <= 1'b1;
                end
            end else if (execDone) begin
                pc          <= nextPc;
                execPhase   <= 1'b0;
                retireValid <= 1'b1;
                if (ctrl.isEbreak) begin
                    halted <= 1'b1;
                end
            end
        end
    end

    // pick the half of the 64-bit word that pc points at
    always_ff @(posedge clk) begin
        if (fetchReq.valid && fetchGnt) begin
            inst <= pc[2] ? memRdata[63:32] : memRdata[31:0];
        end
    end

endmodule

// File: src/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  logic [31:0]            inst,
    output rvPkg::ctrlT            ctrl,
    output logic [rvPkg::xLen-1:0] imm
);
    import rvPkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       isShift;
    logic       immShiftOk;
    logic       regOk;
    logic       wordF3;

    function automatic aluOpE aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    assign funct3     = inst[14:12];
    assign funct7     = inst[31:25];
    assign isShift    = funct3 == 3'b001 || funct3 == 3'b101;
    // 6-bit shamt, only srai may set bit 30
    assign immShiftOk = inst[31:26] == 6'b000000 ||
                        (funct3 == 3'b101 && inst[31:26] == 6'b010000);
    assign regOk      = funct7 == 7'b0000000 ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
    assign wordF3     = funct3 == 3'b000 || isShift;

    // anything not matched stays an all-zero no-op
    always_comb begin
        ctrl = '0;
        case (opcodeE'(inst[6:0]))
            opLui: begin
                ctrl.aluOp   = aluCopyB;
                ctrl.bSelImm = 1'b1;
                ctrl.regWr   = 1'b1;
                ctrl.immKind = immU;
            end
            opAuipc: begin
                ctrl.aluOp   = aluAdd;
                ctrl.aSelPc  = 1'b1;
                ctrl.bSelImm = 1'b1;
                ctrl.regWr   = 1'b1;
                ctrl.immKind = immU;
            end
            opJal: begin
                ctrl.regWr   = 1'b1;
                ctrl.branch  = brJal;
                ctrl.immKind = immJ;
            end
            opJalr: begin
                if (funct3 == 3'b000) begin
                    ctrl.regWr   = 1'b1;
                    ctrl.branch  = brJalr;
                    ctrl.immKind = immI;
                end
            end
            opBranch: begin
                ctrl.aluOp   = aluSub;
                ctrl.immKind = immB;
                case (funct3)
                    3'b000:  ctrl.branch = brEq;
                    3'b001:  ctrl.branch = brNe;
                    3'b100:  ctrl.branch = brLt;
                    3'b101:  ctrl.branch = brGe;
                    3'b110:  ctrl.branch = brLtu;
                    3'b111:  ctrl.branch = brGeu;
                    default: ctrl.branch = brNone;
                endcase
            end
            opLoad: begin
                if (funct3 != 3'b111) begin
                    ctrl.memRd   = 1'b1;
                    ctrl.regWr   = 1'b1;
                    ctrl.bSelImm = 1'b1;
                    ctrl.memOp   = memOpE'(funct3);
                    ctrl.immKind = immI;
                end
            end
            opStore: begin
                if (!funct3[2]) begin
                    ctrl.memWr   = 1'b1;
                    ctrl.bSelImm = 1'b1;
                    ctrl.memOp   = memOpE'(funct3);
                    ctrl.immKind = immS;
                end
            end
            opImm, opImmW: begin
                ctrl.isWord = inst[3];
                if (inst[3] ? (wordF3 && (!isShift || regOk)) : (!isShift || immShiftOk)) begin
                    ctrl.aluOp   = aluFromFunct(funct3, funct3 == 3'b101 && inst[30]);
                    ctrl.regWr   = 1'b1;
                    ctrl.bSelImm = 1'b1;
                    ctrl.immKind = immI;
                end
            end
            opReg, opRegW: begin
                ctrl.isWord = inst[3];
                if (regOk && (!inst[3] || wordF3)) begin
                    ctrl.aluOp = aluFromFunct(funct3, inst[30]);
                    ctrl.regWr = 1'b1;
                end
            end
            opSystem: ctrl.isEbreak = inst == 32'h00100073;
            default: ;
        endcase
    end

    always_comb begin
        case (ctrl.immKind)
            immS:    imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
            immB:    imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            immU:    imm = {{32{inst[31]}}, inst[31:12], 12'b0};
            immJ:    imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{52{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// File: src/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  logic                   wen,
    input  logic [rvPkg::xLen-1:0] wdata,
    output logic [rvPkg::xLen-1:0] rs1Data,
    output logic [rvPkg::xLen-1:0] rs2Data
);
    import rvPkg::*;

    logic [xLen-1:0] regs [32];

    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

    // x0 is never written, so it keeps its reset zero
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: src/intAlu.sv
`timescale 1ns/1ps

module intAlu (
    input  rvPkg::ctrlT            ctrl,
    input  logic [rvPkg::xLen-1:0] pc,
    input  logic [rvPkg::xLen-1:0] rs1Data,
    input  logic [rvPkg::xLen-1:0] rs2Data,
    input  logic [rvPkg::xLen-1:0] imm,
    output logic [rvPkg::xLen-1:0] result,
    output logic                   less,
    output logic                   zero
);
    import rvPkg::*;

    logic [xLen-1:0] opA;
    logic [xLen-1:0] opB;
    logic [xLen-1:0] shiftA;
    logic [xLen-1:0] diff;
    logic [xLen-1:0] raw;
    logic [5:0]      shamt;
    logic            signedLess;
    logic            unsignedLess;

    assign opA          = ctrl.aSelPc ? pc : rs1Data;
    assign opB          = ctrl.bSelImm ? imm : rs2Data;
    assign diff         = opA - opB;
    assign signedLess   = $signed(opA) < $signed(opB);
    assign unsignedLess = opA < opB;

    // word shifts use 5 bits of shamt on the low half of A
    assign shamt  = ctrl.isWord ? {1'b0, opB[4:0]} : opB[5:0];
    assign shiftA = !ctrl.isWord          ? opA :
                    (ctrl.aluOp == aluSra) ? {{32{opA[31]}}, opA[31:0]} :
                                             {32'b0, opA[31:0]};

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:   raw = opA + opB;
            aluSub:   raw = diff;
            aluSll:   raw = opA << shamt;
            aluSlt:   raw = xLen'(signedLess);
            aluSltu:  raw = xLen'(unsignedLess);
            aluXor:   raw = opA ^ opB;
            aluSrl:   raw = shiftA >> shamt;
            aluSra:   raw = $signed(shiftA) >>> shamt;
            aluOr:    raw = opA | opB;
            aluAnd:   raw = opA & opB;
            aluCopyB: raw = opB;
            default:  raw = '0;
        endcase
    end

    // truncate and sign-extend for the W forms
    assign result = ctrl.isWord ? {{32{raw[31]}}, raw[31:0]} : raw;

    assign less = (ctrl.branch == brLtu || ctrl.branch == brGeu) ? unsignedLess : signedLess;
    assign zero = diff == '0;

endmodule

// File: src/loadStoreUnit.sv
`timescale 1ns/1ps

module loadStoreUnit (
    input  rvPkg::ctrlT            ctrl,
    input  logic                   execPhase,
    input  logic [rvPkg::xLen-1:0] addr,
    input  logic [rvPkg::xLen-1:0] storeData,
    input  logic                   gnt,
    input  logic [rvPkg::xLen-1:0] rdata,
    output rvPkg::memReqT          memReq,
    output logic [rvPkg::xLen-1:0] loadData,
    output logic                   done
);
    import rvPkg::*;

    logic              active;
    logic [2:0]        byteOff;
    logic [7:0]        sizeMask;
    logic [15:0]       maskWide;
    logic [2*xLen-1:0] dataWide;
    logic [2*xLen-1:0] readWide;
    logic [xLen-1:0]   lane;

    assign active  = execPhase && (ctrl.memRd || ctrl.memWr);
    assign byteOff = addr[2:0];
    assign done    = !active || gnt;

    always_comb begin
        case (ctrl.memOp)
            memByte, memByteU: sizeMask = 8'h01;
            memHalf, memHalfU: sizeMask = 8'h03;
            memWord, memWordU: sizeMask = 8'h0f;
            default:           sizeMask = 8'hff;
        endcase
    end

    // lanes rotate inside the word, so misaligned accesses wrap around
    assign maskWide = {8'h00, sizeMask} << byteOff;
    assign dataWide = {{xLen{1'b0}}, storeData} << {byteOff, 3'b000};
    assign readWide = {rdata, rdata} >> {byteOff, 3'b000};
    assign lane     = readWide[xLen-1:0];

    always_comb begin
        memReq       = '0;
        memReq.valid = active;
        memReq.write = ctrl.memWr;
        memReq.addr  = addr;
        memReq.wdata = dataWide[xLen-1:0] | dataWide[2*xLen-1:xLen];
        memReq.wmask = ctrl.memWr ? (maskWide[7:0] | maskWide[15:8]) : 8'h00;
    end

    always_comb begin
        case (ctrl.memOp)
            memByte:  loadData = {{56{lane[7]}}, lane[7:0]};
            memByteU: loadData = {56'b0, lane[7:0]};
            memHalf:  loadData = {{48{lane[15]}}, lane[15:0]};
            memHalfU: loadData = {48'b0, lane[15:0]};
            memWord:  loadData = {{32{lane[31]}}, lane[31:0]};
            memWordU: loadData = {32'b0, lane[31:0]};
            default:  loadData = lane;
        endcase
    end

endmodule

// File: src/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  rvPkg::memReqT loadReq,
    input  rvPkg::memReqT lsuReq,
    input  rvPkg::memReqT fetchReq,
    output rvPkg::memReqT memReq,
    output logic          loadGnt,
    output logic          lsuGnt,
    output logic          fetchGnt
);

    // loader first, then load/store, then fetch
    always_comb begin
        memReq   = '0;
        loadGnt  = 1'b0;
        lsuGnt   = 1'b0;
        fetchGnt = 1'b0;
        if (loadReq.valid) begin
            memReq  = loadReq;
            loadGnt = 1'b1;
        end else if (lsuReq.valid) begin
            memReq = lsuReq;
            lsuGnt = 1'b1;
        end else if (fetchReq.valid) begin
            memReq   = fetchReq;
            fetchGnt = 1'b1;
        end
    end

endmodule

// File: src/unifiedMem.sv
`timescale 1ns/1ps

module unifiedMem #(
    parameter int memWords = 1024
) (
    input  logic                   clk,
    input  rvPkg::memReqT          req,
    output logic [rvPkg::xLen-1:0] rdata
);
    import rvPkg::*;

    localparam int idxW = (memWords > 1) ? $clog2(memWords) : 1;

    logic [xLen-1:0]   mem [memWords];
    logic [xLen-4:0]   wordAddr;
    logic [idxW-1:0]   idx;

    // word address folded into the array depth
    assign wordAddr = req.addr[xLen-1:3] % (xLen-3)'(memWords);
    assign idx      = idxW'(wordAddr);
    assign rdata    = mem[idx];

    always_ff @(posedge clk) begin
        if (req.valid && req.write) begin
            for (int b = 0; b < 8; b++) begin
                if (req.wmask[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: src/rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter int                     memWords = 1024,
    parameter logic [rvPkg::xLen-1:0] resetPc  = '0
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   run,
    input  rvPkg::memReqT          loadReq,
    output logic [rvPkg::xLen-1:0] pc,
    output logic [31:0]            inst,
    output logic                   halted,
    output rvPkg::retireT          retire
);
    import rvPkg::*;

    ctrlT            ctrl;
    memReqT          fetchReq;
    memReqT          lsuReq;
    memReqT          memReq;
    logic [xLen-1:0] retPc;
    logic [31:0]     retInst;
    logic [4:0]      retRd;
    logic            retRdWr;
    logic [xLen-1:0] retData;
    logic [xLen-1:0] imm;
    logic [xLen-1:0] rs1Data;
    logic [xLen-1:0] rs2Data;
    logic [xLen-1:0] aluResult;
    logic [xLen-1:0] loadData;
    logic [xLen-1:0] memRdata;
    logic [xLen-1:0] wbData;
    logic            aluLess;
    logic            aluZero;
    logic            lsuGnt;
    logic            fetchGnt;
    logic            execPhase;
    logic            execDone;
    logic            retireValid;
    logic            isJump;
    logic            regWen;

    fetchUnit #(.resetPc(resetPc)) uFetch (
        .clk, .rstN, .run, .fetchGnt, .memRdata, .ctrl, .imm, .rs1Data,
        .aluLess, .aluZero, .execDone, .fetchReq, .pc, .inst, .execPhase,
        .retireValid, .halted
    );

    instDecoder uDecoder (.inst, .ctrl, .imm);

    regFile uRegs (
        .clk, .rstN, .rs1(inst[19:15]), .rs2(inst[24:20]), .rd(inst[11:7]),
        .wen(regWen), .wdata(wbData), .rs1Data, .rs2Data
    );

    intAlu uAlu (
        .ctrl, .pc, .rs1Data, .rs2Data, .imm,
        .result(aluResult), .less(aluLess), .zero(aluZero)
    );

    loadStoreUnit uLsu (
        .ctrl, .execPhase, .addr(aluResult), .storeData(rs2Data), .gnt(lsuGnt),
        .rdata(memRdata), .memReq(lsuReq), .loadData, .done(execDone)
    );

    memArbiter uArb (
        .loadReq, .lsuReq, .fetchReq, .memReq,
        .loadGnt(), .lsuGnt, .fetchGnt
    );

    unifiedMem #(.memWords(memWords)) uMem (.clk, .req(memReq), .rdata(memRdata));

    // writeback source: load data, link address or ALU result
    assign isJump = ctrl.branch == brJal || ctrl.branch == brJalr;
    assign wbData = ctrl.memRd ? loadData : (isJump ? pc + xLen'(4) : aluResult);
    assign regWen = execPhase && execDone && ctrl.regWr;

    // pc moves on at the closing edge, so the record is captured there
    always_ff @(posedge clk) begin
        if (execPhase && execDone) begin
            retPc   <= pc;
            retInst <= inst;
            retRd   <= inst[11:7];
            retRdWr <= ctrl.regWr && inst[11:7] != 5'd0;
            retData <= wbData;
        end
    end

    assign retire = '{valid: retireValid, pc: retPc, inst: retInst, rdAddr: retRd,
                      rdWr: retRdWr, rdData: retData};

endmodule

// File: test/testProgram.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

// RV64I encoders, field order as in the ISA manual
function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] bType(input logic [12:0] imm, input logic [2:0] f3,
                                      input logic [4:0] rs1, input logic [4:0] rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// kinds: 1 ALU, 2 word ops, 3 loads and stores, 4 control flow, 5 halt
task automatic buildProgram();
    logic [31:0] trap;
    // lands on x30 if a jump fails to skip it
    trap = iType(12'd1, 3'd0, 30, 0, 7'h13);
    buildPc = resetPc;
    appendInst(iType(12'h400, 3'd3, 1, 0, 7'h03), 3, 1, opA);
    appendInst(iType(12'h408, 3'd3, 2, 0, 7'h03), 3, 2, opB);
    appendInst(rType(7'h00, 3'd0, 3, 1, 2, 7'h33), 1, 3, opA + opB);
    appendInst(rType(7'h20, 3'd0, 4, 1, 2, 7'h33), 1, 4, opA - opB);
    appendInst(rType(7'h00, 3'd7, 5, 1, 2, 7'h33), 1, 5, opA & opB);
    appendInst(rType(7'h00, 3'd6, 6, 1, 2, 7'h33), 1, 6, opA | opB);
    appendInst(rType(7'h00, 3'd4, 7, 1, 2, 7'h33), 1, 7, opA ^ opB);
    appendInst(rType(7'h00, 3'd1, 8, 1, 2, 7'h33), 1, 8, opA << opB[5:0]);
    appendInst(rType(7'h00, 3'd5, 9, 1, 2, 7'h33), 1, 9, opA >> opB[5:0]);
    appendInst(rType(7'h20, 3'd5, 10, 1, 2, 7'h33), 1, 10, $signed(opA) >>> opB[5:0]);
    appendInst(rType(7'h00, 3'd2, 11, 1, 2, 7'h33), 1, 11,
               {63'b0, $signed(opA) < $signed(opB)});
    appendInst(rType(7'h00, 3'd3, 12, 1, 2, 7'h33), 1, 12, {63'b0, opA < opB});
    // addi with -5
    appendInst(iType(12'hffb, 3'd0, 13, 1, 7'h13), 1, 13, opA - 64'd5);
    appendInst(uType(20'h80001, 14, 7'h37), 1, 14, 64'hffff_ffff_8000_1000);
    appendInst(uType(20'h00012, 15, 7'h17), 1, 15, buildPc + 64'h12000);
    appendInst(rType(7'h00, 3'd0, 16, 1, 2, 7'h3b), 2, 16, signExtend32(opA[31:0] + opB[31:0]));
    appendInst(rType(7'h20, 3'd0, 17, 1, 2, 7'h3b), 2, 17, signExtend32(opA[31:0] - opB[31:0]));
    appendInst(rType(7'h20, 3'd5, 18, 1, 2, 7'h3b), 2, 18,
               signExtend32($signed(opA[31:0]) >>> opB[4:0]));
    // addiw of -1 on the most negative word overflows to positive
    appendInst(uType(20'h80000, 20, 7'h37), 2, 20, 64'hffff_ffff_8000_0000);
    appendInst(iType(12'hfff, 3'd0, 21, 20, 7'h1b), 2, 21, 64'h0000_0000_7fff_ffff);
    appendInst(sType(12'h411, 3'd0, 0, 1), 3, 0, '0);
    appendInst(sType(12'h414, 3'd1, 0, 1), 3, 0, '0);
    appendInst(sType(12'h418, 3'd2, 0, 1), 3, 0, '0);
    appendInst(iType(12'h411, 3'd0, 22, 0, 7'h03), 3, 22, {{56{opA[7]}}, opA[7:0]});
    appendInst(iType(12'h411, 3'd4, 23, 0, 7'h03), 3, 23, {56'b0, opA[7:0]});
    appendInst(iType(12'h414, 3'd1, 24, 0, 7'h03), 3, 24, {{48{opA[15]}}, opA[15:0]});
    appendInst(iType(12'h414, 3'd5, 25, 0, 7'h03), 3, 25, {48'b0, opA[15:0]});
    appendInst(iType(12'h418, 3'd2, 26, 0, 7'h03), 3, 26, signExtend32(opA[31:0]));
    appendInst(iType(12'h418, 3'd6, 27, 0, 7'h03), 3, 27, {32'b0, opA[31:0]});
    appendInst(iType(12'h410, 3'd3, 28, 0, 7'h03), 3, 28,
               {memD[63:48], opA[15:0], memD[31:16], opA[7:0], memD[7:0]});
    appendInst(iType(12'h418, 3'd3, 29, 0, 7'h03), 3, 29, {memC[63:32], opA[31:0]});
    // taken branches skip the trap, not-taken ones fall through
    appendInst(bType(13'd8, 3'd0, 1, 1), 4, 0, '0);
    appendSkipped(trap);
    appendInst(bType(13'd8, 3'd1, 1, 1), 4, 0, '0);
    appendInst(bType(13'd8, 3'd4, 20, 0), 4, 0, '0);
    appendSkipped(trap);
    appendInst(bType(13'd8, 3'd6, 20, 0), 4, 0, '0);
    appendInst(bType(13'd8, 3'd5, 0, 20), 4, 0, '0);
    appendSkipped(trap);
    appendInst(bType(13'd8, 3'd7, 0, 20), 4, 0, '0);
    appendInst(jType(21'd8, 31), 4, 31, buildPc + 64'd4);
    appendSkipped(trap);
    appendInst(uType(20'h00000, 30, 7'h17), 4, 30, buildPc);
    appendInst(iType(12'd12, 3'd0, 31, 30, 7'h67), 4, 31, buildPc + 64'd4);
    appendSkipped(trap);
    appendInst(32'h0010_0073, 5, 0, '0);
endtask

`endif

// File: test/coreTb.sv
`timescale 1ns/1ps

module coreTb;
    import rvPkg::*;

    localparam logic [63:0] resetPc   = 64'h0;
    localparam int          maxInsts  = 64;
    localparam int          haltLimit = 2000;

    logic        clk = 1'b0;
    logic        rstN;
    logic        run;
    memReqT      loadReq;
    logic [63:0] pc;
    logic [31:0] inst;
    logic        halted;
    retireT      retire;

    // program image and the retire records it should produce
    logic [31:0] progWords [maxInsts];
    logic [63:0] expPc [maxInsts];
    logic [31:0] expInst [maxInsts];
    logic [4:0]  expRd [maxInsts];
    logic [63:0] expData [maxInsts];
    int          expKind [maxInsts];
    int          progLen = 0;
    int          nExp = 0;
    logic [63:0] buildPc;

    // operands and background data in the data area
    logic [63:0] opA;
    logic [63:0] opB;
    logic [63:0] memC;
    logic [63:0] memD;

    int    cycle = 0;
    int    lastRetCycle = 0;
    int    retCount = 0;
    logic  haltSeen = 1'b0;
    logic  timedOut = 1'b0;
    int    errs [1:6] = '{default: 0};
    string testName [1:6] = '{"ALU results", "word operations", "loads and stores",
                              "control flow", "reset and halt", "two-cycle rhythm"};

    rvCore #(.memWords(1024), .resetPc(resetPc)) dut_i (
        .clk, .rstN, .run, .loadReq, .pc, .inst, .halted, .retire
    );

    always #50 clk = ~clk;

    function automatic logic [63:0] signExtend32(input logic [31:0] x);
        return {{32{x[31]}}, x};
    endfunction

    task automatic recordFail(input int testId, input string msg);
        errs[testId]++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic appendSkipped(input logic [31:0] word);
        progWords[progLen] = word;
        progLen++;
        buildPc = buildPc + 64'd4;
    endtask

    task automatic appendInst(input logic [31:0] word, input int kind, input logic [4:0] rd,
                              input logic [63:0] data);
        expPc[nExp]   = buildPc;
        expInst[nExp] = word;
        expRd[nExp]   = rd;
        expData[nExp] = data;
        expKind[nExp] = kind;
        nExp++;
        appendSkipped(word);
    endtask

    `include "testProgram.svh"

    task automatic writeWord(input logic [63:0] addr, input logic [63:0] data);
        @(negedge clk);
        loadReq.valid = 1'b1;
        loadReq.write = 1'b1;
        loadReq.addr  = addr;
        loadReq.wdata = data;
        loadReq.wmask = 8'hff;
    endtask

    task automatic loadProgram();
        // two instructions per 64-bit word, lower address in the low half
        for (int i = 0; i < progLen; i += 2) begin
            writeWord(resetPc + 64'(i * 4), {progWords[i+1], progWords[i]});
        end
        writeWord(64'h400, opA);
        writeWord(64'h408, opB);
        writeWord(64'h410, memD);
        writeWord(64'h418, memC);
        @(negedge clk);
        loadReq = '0;
    endtask

    // retire.valid seen here is the one of the cycle that just ended
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (retire.valid) begin
            retCount     <= retCount + 1;
            lastRetCycle <= cycle;
        end
        if (halted) begin
            haltSeen <= 1'b1;
        end
    end

    assert property (@(negedge clk) disable iff (!rstN)
        retire.valid && retCount < nExp |->
            retire.rdWr == (expRd[retCount] != 5'd0) &&
            (!retire.rdWr || (retire.rdAddr == expRd[retCount] &&
                              retire.rdData == expData[retCount])))
        else recordFail(expKind[retCount],
                        $sformatf("retire %0d wrote x%0d = %h (wr %0b), expected x%0d = %h",
                                  retCount, retire.rdAddr, retire.rdData, retire.rdWr,
                                  expRd[retCount], expData[retCount]));

    assert property (@(negedge clk) disable iff (!rstN)
        retire.valid && retCount < nExp |-> retire.pc == expPc[retCount])
        else recordFail(retCount == 0 ? 5 : 4,
                        $sformatf("retire %0d has pc %h, expected %h",
                                  retCount, retire.pc, expPc[retCount]));

    // the instruction register still holds the retiring word in this cycle
    assert property (@(negedge clk) disable iff (!rstN)
        retire.valid && retCount < nExp |->
            retire.inst == expInst[retCount] && inst == expInst[retCount])
        else recordFail(4, $sformatf("retire %0d carries %h with inst %h, expected %h",
                                     retCount, retire.inst, inst, expInst[retCount]));

    assert property (@(negedge clk) disable iff (!rstN)
        retire.valid |-> retCount < nExp)
        else recordFail(5, "an instruction retired after the ebreak");

    assert property (@(negedge clk) disable iff (!rstN)
        haltSeen |-> halted)
        else recordFail(5, "halted dropped after the ebreak");

    assert property (@(negedge clk) disable iff (!rstN)
        retire.valid && retCount > 0 |-> cycle - lastRetCycle == 2)
        else recordFail(6, $sformatf("retire %0d came %0d cycles after the previous one",
                                     retCount, cycle - lastRetCycle));

    initial begin
        int passed;
        int total;
        rstN    = 1'b0;
        run     = 1'b0;
        loadReq = '0;
        passed  = 0;
        total   = 0;
        void'($urandom(32'h40ce));
        opA  = {$urandom, $urandom};
        opB  = {$urandom, $urandom};
        memC = {$urandom, $urandom};
        memD = {$urandom, $urandom};
        buildProgram();

        repeat (5) @(negedge clk);
        assert (pc == resetPc && !halted && !retire.valid)
            else recordFail(5, "core state is wrong during reset");
        rstN = 1'b1;
        loadProgram();
        @(negedge clk);
        run = 1'b1;

        for (int i = 0; i < haltLimit && !halted; i++) begin
            @(negedge clk);
        end
        timedOut = !halted;
        if (timedOut) begin
            $display("timeout: the core did not halt within %0d cycles", haltLimit);
        end else begin
            // a quiet window after the halt
            repeat (20) @(negedge clk);
        end
        assert (retCount == nExp) else begin
            errs[5]++;
            $display("not every instruction retired: %0d of %0d", retCount, nExp);
        end

        for (int t = 1; t <= 6; t++) begin
            $display("test %0d, %s: %s (%0d errors)", t, testName[t],
                     errs[t] == 0 ? "passed" : "failed", errs[t]);
            if (errs[t] == 0) begin
                passed++;
            end
            total += errs[t];
        end
        $display("summary: 6 tests, %0d passed, %0d failed, %0d errors",
                 passed, 6 - passed, total);
        if (total == 0 && !timedOut) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+test
src/rvPkg.sv
src/fetchUnit.sv
src/instDecoder.sv
src/regFile.sv
src/intAlu.sv
src/loadStoreUnit.sv
src/memArbiter.sv
src/unifiedMem.sv
src/rvCore.sv
test/coreTb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
TOP       := coreTb
FILELIST  := list.f
PASSMSG   := Everything OK

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "$(PASSMSG)"

clean:
	rm -rf obj_dir
